// File: fsq_cfg.svh
`ifndef FSQ_CFG_SVH
`define FSQ_CFG_SVH

// queue geometry
`define FSQ_SIZE 16
`define FSQ_WIDTH 4

// address and stream offset widths
`define VADDR_SIZE 32
`define PREDICTION_WIDTH 4

// commit bus
`define COMMIT_WIDTH 4
`define COMMIT_NUM_BITS 3

// retired instructions not yet matched to a stream
`define COMMIT_ACC_BITS 8

`endif

// File: fetch_stream_pkg.sv
`default_nettype none

`include "fsq_cfg.svh"

package fetch_stream_pkg;

    // dir flips every time idx wraps
    typedef struct packed {
        logic                  dir;
        logic [`FSQ_WIDTH-1:0] idx;
    } fsq_idx_t;

    // size is the offset of the last instruction in the stream
    typedef struct packed {
        logic [`VADDR_SIZE-1:0]       start_addr;
        logic [`PREDICTION_WIDTH-1:0] size;
        logic                         taken;
        logic [`VADDR_SIZE-1:0]       target;
    } fetch_stream_t;

    typedef struct packed {
        logic          en;
        fsq_idx_t      idx;
        fetch_stream_t stream;
    } fetch_req_t;

    function automatic fsq_idx_t fsq_idx_inc(input fsq_idx_t ptr);
        fsq_idx_t nxt;
        if (ptr.idx == `FSQ_WIDTH'(`FSQ_SIZE - 1)) begin
            nxt.idx = '0;
            nxt.dir = ~ptr.dir;
        end else begin
            nxt.idx = ptr.idx + 1'b1;
            nxt.dir = ptr.dir;
        end
        return nxt;
    endfunction

endpackage

`default_nettype wire

// File: branch_resolve_pkg.sv
`default_nettype none

`include "fsq_cfg.svh"

package branch_resolve_pkg;

    import fetch_stream_pkg::*;

    // mispredict reported by the back end
    typedef struct packed {
        logic                         en;
        fsq_idx_t                     idx;
        logic [`PREDICTION_WIDTH-1:0] offset;
        logic                         taken;
        logic [`VADDR_SIZE-1:0]       target;
    } br_redirect_t;

    // resolved outcome kept per queue entry
    typedef struct packed {
        logic                         mispredict;
        logic                         taken;
        logic [`VADDR_SIZE-1:0]       target;
        logic [`PREDICTION_WIDTH-1:0] offset;
    } wb_info_t;

    // predictor training word
    typedef struct packed {
        logic [`VADDR_SIZE-1:0] start_addr;
        logic                   taken;
        logic [`VADDR_SIZE-1:0] target;
        logic                   mispredict;
    } bp_update_t;

endpackage

`default_nettype wire

// File: fsq_alloc.sv
`timescale 1ns/100ps
`default_nettype none

`include "fsq_cfg.svh"

module fsq_alloc
    import fetch_stream_pkg::*, branch_resolve_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   pred_en,
    input  wire br_redirect_t           br_redirect,
    input  wire fsq_idx_t               commit_ptr,
    output fsq_idx_t                    tail_ptr,
    output logic                        pred_stall,
    output logic                        enq_we,
    output logic                        squash,
    output logic [`VADDR_SIZE-1:0]      squash_target
);

    fsq_idx_t tail_inc;
    fsq_idx_t redirect_inc;

    // full when both pointers sit on the same slot one lap apart
    assign pred_stall = (tail_ptr.idx == commit_ptr.idx) && (tail_ptr.dir != commit_ptr.dir);

    assign enq_we = pred_en & ~pred_stall;

    assign tail_inc     = fsq_idx_inc(tail_ptr);
    assign redirect_inc = fsq_idx_inc(br_redirect.idx);

    // cut back to the stream after the mispredicted one
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail_ptr <= '0;
        end else if (br_redirect.en) begin
            tail_ptr <= redirect_inc;
        end else if (enq_we) begin
            tail_ptr <= tail_inc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            squash <= 1'b0;
        end else begin
            squash <= br_redirect.en;
        end
    end

    always_ff @(posedge clk) begin
        if (br_redirect.en) begin
            squash_target <= br_redirect.target;
        end
    end

    // the back end can only resolve streams that were already enqueued
    a_redirect_not_tail: assert property (
        @(posedge clk) disable iff (rst)
        br_redirect.en |-> (br_redirect.idx != tail_ptr)
    ) else $error("redirect names the tail entry");

endmodule

`default_nettype wire

// File: fsq_fetch_issue.sv
`timescale 1ns/100ps
`default_nettype none

`include "fsq_cfg.svh"

module fsq_fetch_issue
    import fetch_stream_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire fsq_idx_t      tail_ptr,
    input  wire logic          cache_ready,
    input  wire logic          ibuf_full,
    input  wire logic          redirect,
    input  wire fetch_stream_t fetch_stream,
    output fsq_idx_t           search_ptr,
    output logic               fetch_load,
    output logic               cache_flush,
    output fetch_req_t         fetch_req
);

    fsq_idx_t search_q;
    logic     realign;
    logic     pending;
    logic     req_en;
    fsq_idx_t req_idx;

    // after a redirect the tail already holds entry plus one
    assign search_ptr = realign ? tail_ptr : search_q;

    assign pending     = (search_ptr != tail_ptr);
    assign fetch_load  = cache_ready & ~ibuf_full & ~redirect;
    assign cache_flush = redirect;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            search_q <= '0;
            realign  <= 1'b0;
            req_en   <= 1'b0;
            req_idx  <= '0;
        end else begin
            realign <= redirect;
            if (redirect) begin
                req_en <= 1'b0;
            end else if (fetch_load) begin
                req_en  <= pending;
                req_idx <= search_ptr;
            end
            if (!redirect) begin
                if (fetch_load && pending) begin
                    search_q <= fsq_idx_inc(search_ptr);
                end else begin
                    search_q <= search_ptr;
                end
            end
        end
    end

    assign fetch_req.en     = req_en;
    assign fetch_req.idx    = req_idx;
    assign fetch_req.stream = fetch_stream;

    a_flush_drops_req: assert property (
        @(posedge clk) disable iff (rst)
        cache_flush |=> !fetch_req.en
    ) else $error("fetch request survived a cache flush");

endmodule

`default_nettype wire

// File: fsq_entry_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "fsq_cfg.svh"

module fsq_entry_store
    import fetch_stream_pkg::*, branch_resolve_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          enq_we,
    input  wire fsq_idx_t      tail_ptr,
    input  wire fetch_stream_t pred_stream,
    input  wire logic          fetch_load,
    input  wire fsq_idx_t      search_ptr,
    input  wire br_redirect_t  br_redirect,
    input  wire fsq_idx_t      commit_ptr,
    output fetch_stream_t      fetch_stream,
    output fetch_stream_t      commit_stream,
    output wb_info_t           commit_wb
);

    fetch_stream_t          streams [`FSQ_SIZE];
    wb_info_t               wb_mem  [`FSQ_SIZE];
    logic [`FSQ_SIZE-1:0]   mispredict_q;

    always_ff @(posedge clk) begin
        if (enq_we) begin
            streams[tail_ptr.idx] <= pred_stream;
        end
    end

    always_ff @(posedge clk) begin
        if (br_redirect.en) begin
            wb_mem[br_redirect.idx.idx].taken      <= br_redirect.taken;
            wb_mem[br_redirect.idx.idx].target     <= br_redirect.target;
            wb_mem[br_redirect.idx.idx].offset     <= br_redirect.offset;
        end
    end

    // a freshly written stream starts with no resolved mispredict
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mispredict_q <= '0;
        end else begin
            if (enq_we) begin
                mispredict_q[tail_ptr.idx] <= 1'b0;
            end
            if (br_redirect.en) begin
                mispredict_q[br_redirect.idx.idx] <= 1'b1;
            end
        end
    end

    // registered read for the cache port
    always_ff @(posedge clk) begin
        if (fetch_load) begin
            fetch_stream <= streams[search_ptr.idx];
        end
    end

    // commit ports read the head directly
    assign commit_stream = streams[commit_ptr.idx];

    always_comb begin
        commit_wb            = wb_mem[commit_ptr.idx];
        commit_wb.mispredict = mispredict_q[commit_ptr.idx];
    end

endmodule

`default_nettype wire

// File: fsq_commit.sv
`timescale 1ns/100ps
`default_nettype none

`include "fsq_cfg.svh"

module fsq_commit
    import fetch_stream_pkg::*, branch_resolve_pkg::*;
(
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic [`COMMIT_NUM_BITS-1:0] commit_num,
    input  wire fetch_stream_t               commit_stream,
    input  wire wb_info_t                    commit_wb,
    output fsq_idx_t                         commit_ptr,
    output logic                             bp_update_en,
    output bp_update_t                       bp_update
);

    localparam int ACC_W = `COMMIT_ACC_BITS;

    logic [ACC_W-1:0]             acc;
    logic [ACC_W:0]               acc_sum;
    logic [ACC_W-1:0]             retire_amt;
    logic [`PREDICTION_WIDTH-1:0] retire_off;
    logic [ACC_W-1:0]             retire_thr;
    logic                         retire;

    // a mispredicted stream ends at the resolved branch
    assign retire_off = commit_wb.mispredict ? commit_wb.offset : commit_stream.size;
    assign retire_thr = {{(ACC_W - `PREDICTION_WIDTH){1'b0}}, retire_off};
    assign retire     = acc > retire_thr;
    assign retire_amt = retire ? retire_thr + 1'b1 : '0;

    assign acc_sum = {1'b0, acc} + {{(ACC_W + 1 - `COMMIT_NUM_BITS){1'b0}}, commit_num};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc          <= '0;
            commit_ptr   <= '0;
            bp_update_en <= 1'b0;
        end else begin
            acc          <= acc_sum[ACC_W-1:0] - retire_amt;
            bp_update_en <= retire;
            if (retire) begin
                commit_ptr <= fsq_idx_inc(commit_ptr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            bp_update.start_addr <= commit_stream.start_addr;
            bp_update.mispredict <= commit_wb.mispredict;
            if (commit_wb.mispredict) begin
                bp_update.taken  <= commit_wb.taken;
                bp_update.target <= commit_wb.target;
            end else begin
                bp_update.taken  <= commit_stream.taken;
                bp_update.target <= commit_stream.target;
            end
        end
    end

    a_acc_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        !acc_sum[ACC_W]
    ) else $error("retired instruction count overflows the accumulator");

    a_commit_num_range: assert property (
        @(posedge clk) disable iff (rst)
        commit_num <= `COMMIT_NUM_BITS'(`COMMIT_WIDTH)
    ) else $error("commit bus retires more than the commit width");

endmodule

`default_nettype wire

// File: fsq_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "fsq_cfg.svh"

module fsq_top
    import fetch_stream_pkg::*, branch_resolve_pkg::*;
(
    input  wire logic                        clk,
    input  wire logic                        rst,
    // predictor
    input  wire logic                        pred_en,
    input  wire fetch_stream_t               pred_stream,
    output fsq_idx_t                         pred_idx,
    output logic                             pred_stall,
    output logic                             squash,
    output logic [`VADDR_SIZE-1:0]           squash_target,
    output logic                             bp_update_en,
    output bp_update_t                       bp_update,
    // instruction cache
    input  wire logic                        cache_ready,
    input  wire logic                        ibuf_full,
    output fetch_req_t                       fetch_req,
    output logic                             cache_flush,
    // back end
    input  wire br_redirect_t                br_redirect,
    input  wire logic [`COMMIT_NUM_BITS-1:0] commit_num
);

    fsq_idx_t      tail_ptr;
    fsq_idx_t      search_ptr;
    fsq_idx_t      commit_ptr;
    logic          enq_we;
    logic          fetch_load;
    fetch_stream_t fetch_stream;
    fetch_stream_t commit_stream;
    wb_info_t      commit_wb;

    assign pred_idx = tail_ptr;

    fsq_alloc i_fsq_alloc (
        .clk           (clk),
        .rst           (rst),
        .pred_en       (pred_en),
        .br_redirect   (br_redirect),
        .commit_ptr    (commit_ptr),
        .tail_ptr      (tail_ptr),
        .pred_stall    (pred_stall),
        .enq_we        (enq_we),
        .squash        (squash),
        .squash_target (squash_target)
    );

    fsq_fetch_issue i_fsq_fetch_issue (
        .clk          (clk),
        .rst          (rst),
        .tail_ptr     (tail_ptr),
        .cache_ready  (cache_ready),
        .ibuf_full    (ibuf_full),
        .redirect     (br_redirect.en),
        .fetch_stream (fetch_stream),
        .search_ptr   (search_ptr),
        .fetch_load   (fetch_load),
        .cache_flush  (cache_flush),
        .fetch_req    (fetch_req)
    );

    fsq_entry_store i_fsq_entry_store (
        .clk           (clk),
        .rst           (rst),
        .enq_we        (enq_we),
        .tail_ptr      (tail_ptr),
        .pred_stream   (pred_stream),
        .fetch_load    (fetch_load),
        .search_ptr    (search_ptr),
        .br_redirect   (br_redirect),
        .commit_ptr    (commit_ptr),
        .fetch_stream  (fetch_stream),
        .commit_stream (commit_stream),
        .commit_wb     (commit_wb)
    );

    fsq_commit i_fsq_commit (
        .clk           (clk),
        .rst           (rst),
        .commit_num    (commit_num),
        .commit_stream (commit_stream),
        .commit_wb     (commit_wb),
        .commit_ptr    (commit_ptr),
        .bp_update_en  (bp_update_en),
        .bp_update     (bp_update)
    );

endmodule

`default_nettype wire

// File: tb_fsq.sv
`timescale 1ns/100ps
`default_nettype none

`include "fsq_cfg.svh"

module tb_fsq
    import fetch_stream_pkg::*, branch_resolve_pkg::*;
;

    // one queue slot as the testbench expects it
    typedef struct packed {
        fsq_idx_t      idx;
        fetch_stream_t stream;
        wb_info_t      wb;
    } model_entry_t;

    logic                        clk;
    logic                        rst;
    logic                        pred_en;
    fetch_stream_t               pred_stream;
    fsq_idx_t                    pred_idx;
    logic                        pred_stall;
    logic                        squash;
    logic [`VADDR_SIZE-1:0]      squash_target;
    logic                        bp_update_en;
    bp_update_t                  bp_update;
    logic                        cache_ready;
    logic                        ibuf_full;
    fetch_req_t                  fetch_req;
    logic                        cache_flush;
    br_redirect_t                br_redirect;
    logic [`COMMIT_NUM_BITS-1:0] commit_num;

    model_entry_t q_model[$];
    fetch_req_t   fetched[$];
    fsq_idx_t     tail_m;
    bp_update_t   exp_upd;
    logic         upd_due;
    logic         load_prev;
    logic         retire_m;
    int           acc_m;
    int           off_m;
    int           mis_seen;
    int           pass_cnt;
    int           fail_cnt;
    int           test_err_base;
    string        cur_test;

    fsq_top i_fsq_top (
        .clk           (clk),
        .rst           (rst),
        .pred_en       (pred_en),
        .pred_stream   (pred_stream),
        .pred_idx      (pred_idx),
        .pred_stall    (pred_stall),
        .squash        (squash),
        .squash_target (squash_target),
        .bp_update_en  (bp_update_en),
        .bp_update     (bp_update),
        .cache_ready   (cache_ready),
        .ibuf_full     (ibuf_full),
        .fetch_req     (fetch_req),
        .cache_flush   (cache_flush),
        .br_redirect   (br_redirect),
        .commit_num    (commit_num)
    );

    always #50 clk = ~clk;

    function automatic fsq_idx_t next_idx(input fsq_idx_t p);
        fsq_idx_t n;
        n = p;
        if (p.idx == `FSQ_SIZE - 1) begin
            n.idx = '0;
            n.dir = ~p.dir;
        end else begin
            n.idx = p.idx + 1'b1;
        end
        return n;
    endfunction

    function automatic fetch_stream_t rand_stream();
        fetch_stream_t s;
        s.start_addr = $urandom & 32'hffff_fffc;
        s.size       = 4'($urandom);
        s.taken      = 1'($urandom);
        s.target     = $urandom & 32'hffff_fffc;
        return s;
    endfunction

    // offset of the last instruction that retires with this entry
    function automatic int retire_offset(input model_entry_t e);
        return e.wb.mispredict ? int'(e.wb.offset) : int'(e.stream.size);
    endfunction

    task automatic check_equal(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout in test %s while waiting for %s", cur_test, what);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic open_test(input string name);
        cur_test = name;
        test_err_base = fail_cnt;
    endtask

    task automatic close_test();
        $display("test %-20s done, %0d errors", cur_test, fail_cnt - test_err_base);
    endtask

    // records every loaded request that carries a stream
    always @(negedge clk) begin
        if (!rst && load_prev && fetch_req.en) begin
            fetched.push_back(fetch_req);
        end
        load_prev = !rst && cache_ready && !ibuf_full && !br_redirect.en;
    end

    // predicts the retire edge and the update word
    always @(negedge clk) begin
        if (rst) begin
            acc_m   = 0;
            upd_due = 1'b0;
        end else begin
            check_equal("bp_update_en", upd_due, bp_update_en);
            if (upd_due && bp_update_en) begin
                check_equal("bp_update", exp_upd, bp_update);
            end
            retire_m = 1'b0;
            if (q_model.size() > 0) begin
                off_m    = retire_offset(q_model[0]);
                retire_m = acc_m > off_m;
            end
            acc_m = acc_m + int'(commit_num) - (retire_m ? off_m + 1 : 0);
            upd_due = retire_m;
            if (retire_m) begin
                exp_upd.start_addr = q_model[0].stream.start_addr;
                exp_upd.mispredict = q_model[0].wb.mispredict;
                exp_upd.taken      = q_model[0].wb.mispredict ? q_model[0].wb.taken
                                                              : q_model[0].stream.taken;
                exp_upd.target     = q_model[0].wb.mispredict ? q_model[0].wb.target
                                                              : q_model[0].stream.target;
                if (q_model[0].wb.mispredict) begin
                    mis_seen++;
                end
                void'(q_model.pop_front());
            end
        end
    end

    // starts and ends at a falling edge
    task automatic enqueue_one(output fetch_stream_t s, output fsq_idx_t idx);
        model_entry_t ent;
        s   = rand_stream();
        idx = tail_m;
        check_equal("pred_idx", tail_m, pred_idx);
        check_equal("pred_stall", 1'b0, pred_stall);
        @(posedge clk);
        pred_en     <= 1'b1;
        pred_stream <= s;
        ent.idx    = tail_m;
        ent.stream = s;
        ent.wb     = '0;
        q_model.push_back(ent);
        tail_m = next_idx(tail_m);
        @(posedge clk);
        pred_en <= 1'b0;
        @(negedge clk);
    endtask

    task automatic feed_commits(input int total);
        int left;
        int n;
        left = total;
        while (left > 0) begin
            n = $urandom % (`COMMIT_WIDTH + 1);
            if (n > left) begin
                n = left;
            end
            @(posedge clk);
            commit_num <= n[`COMMIT_NUM_BITS-1:0];
            left -= n;
        end
        @(posedge clk);
        commit_num <= '0;
    endtask

    task automatic reset_state();
        open_test("reset_state");
        check_equal("pred_stall", 1'b0, pred_stall);
        check_equal("fetch_req.en", 1'b0, fetch_req.en);
        check_equal("squash", 1'b0, squash);
        check_equal("cache_flush", 1'b0, cache_flush);
        check_equal("bp_update_en", 1'b0, bp_update_en);
        check_equal("pred_idx", 0, pred_idx);
        close_test();
    endtask

    task automatic fetch_order();
        fetch_stream_t s;
        fsq_idx_t      idx;
        fetch_req_t    exp_q[$];
        fetch_req_t    req;
        int            cycles;
        open_test("fetch_order");
        @(posedge clk);
        cache_ready <= 1'b1;
        fetched.delete();
        @(negedge clk);
        for (int i = 0; i < 6; i++) begin
            enqueue_one(s, idx);
            req.en     = 1'b1;
            req.idx    = idx;
            req.stream = s;
            exp_q.push_back(req);
        end
        cycles = 0;
        while (fetched.size() < exp_q.size()) begin
            @(posedge clk);
            cycles++;
            if (cycles > 50) begin
                abort_on_timeout("fetch requests");
            end
        end
        repeat (3) @(posedge clk);
        check_equal("fetch count", exp_q.size(), fetched.size());
        foreach (exp_q[i]) begin
            check_equal("fetch_req", exp_q[i], fetched[i]);
        end
        @(negedge clk);
        close_test();
    endtask

    task automatic backpressure_full();
        fetch_stream_t s1;
        fetch_stream_t s2;
        fetch_stream_t s;
        fsq_idx_t      i1;
        fsq_idx_t      i2;
        fsq_idx_t      idx;
        fetch_req_t    r1;
        fetch_req_t    r2;
        int            cycles;
        open_test("backpressure_full");
        @(posedge clk);
        cache_ready <= 1'b0;
        fetched.delete();
        @(negedge clk);
        enqueue_one(s1, i1);
        enqueue_one(s2, i2);
        r1 = {1'b1, i1, s1};
        r2 = {1'b1, i2, s2};
        @(posedge clk);
        cache_ready <= 1'b1;
        @(posedge clk);
        ibuf_full <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_equal("held fetch_req", r1, fetch_req);
        end
        @(posedge clk);
        ibuf_full <= 1'b0;
        cycles = 0;
        while (fetched.size() < 2) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                abort_on_timeout("the stream after back-pressure");
            end
        end
        check_equal("first fetch", r1, fetched[0]);
        check_equal("next fetch", r2, fetched[1]);
        @(negedge clk);
        // fill up with no retirement
        while (q_model.size() < `FSQ_SIZE) begin
            enqueue_one(s, idx);
        end
        check_equal("pred_stall when full", 1'b1, pred_stall);
        check_equal("pred_idx when full", tail_m, pred_idx);
        @(posedge clk);
        pred_en     <= 1'b1;
        pred_stream <= rand_stream();
        repeat (2) @(posedge clk);
        pred_en <= 1'b0;
        @(negedge clk);
        check_equal("pred_idx after ignored write", tail_m, pred_idx);
        check_equal("pred_stall still", 1'b1, pred_stall);
        feed_commits(retire_offset(q_model[0]) + 1);
        cycles = 0;
        while (q_model.size() == `FSQ_SIZE) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                abort_on_timeout("the head stream to retire");
            end
        end
        @(negedge clk);
        check_equal("pred_stall after commit", 1'b0, pred_stall);
        check_equal("pred_idx after commit", tail_m, pred_idx);
        check_equal("pred_idx.dir", 1'b1, pred_idx.dir);
        close_test();
    endtask

    task automatic mispredict_redirect();
        br_redirect_t  rd;
        model_entry_t  ent;
        fetch_stream_t s;
        fetch_stream_t e;
        fsq_idx_t      idx;
        fsq_idx_t      e_idx;
        int            pos;
        int            cycles;
        open_test("mispredict_redirect");
        // this stream is loaded for the cache and then held there
        enqueue_one(s, idx);
        @(posedge clk);
        ibuf_full <= 1'b1;
        @(negedge clk);
        check_equal("fetch_req.en before flush", 1'b1, fetch_req.en);
        pos = q_model.size() - 4;
        ent = q_model[pos];
        rd.en     = 1'b1;
        rd.idx    = ent.idx;
        rd.offset = 4'($urandom % (int'(ent.stream.size) + 1));
        rd.taken  = 1'($urandom);
        rd.target = $urandom & 32'hffff_fffc;
        @(posedge clk);
        br_redirect <= rd;
        fetched.delete();
        ent.wb.mispredict = 1'b1;
        ent.wb.taken      = rd.taken;
        ent.wb.target     = rd.target;
        ent.wb.offset     = rd.offset;
        q_model[pos] = ent;
        while (q_model.size() > pos + 1) begin
            void'(q_model.pop_back());
        end
        tail_m = next_idx(rd.idx);
        @(negedge clk);
        check_equal("cache_flush", 1'b1, cache_flush);
        check_equal("squash early", 1'b0, squash);
        @(posedge clk);
        br_redirect <= '0;
        @(negedge clk);
        check_equal("squash", 1'b1, squash);
        check_equal("squash_target", rd.target, squash_target);
        check_equal("cache_flush after", 1'b0, cache_flush);
        check_equal("fetch_req.en after flush", 1'b0, fetch_req.en);
        check_equal("pred_idx", tail_m, pred_idx);
        @(negedge clk);
        check_equal("squash width", 1'b0, squash);
        enqueue_one(e, e_idx);
        @(posedge clk);
        ibuf_full <= 1'b0;
        cycles = 0;
        while (fetched.size() < 1) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                abort_on_timeout("the first stream after the redirect");
            end
        end
        check_equal("fetch after redirect", {1'b1, e_idx, e}, fetched[0]);
        @(negedge clk);
        close_test();
    endtask

    task automatic commit_update();
        int total;
        int cycles;
        int mis_base;
        open_test("commit_update");
        total    = 0;
        mis_base = mis_seen;
        foreach (q_model[i]) begin
            total += retire_offset(q_model[i]) + 1;
        end
        feed_commits(total);
        cycles = 0;
        while (q_model.size() > 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 400) begin
                abort_on_timeout("all streams to retire");
            end
        end
        repeat (2) @(negedge clk);
        check_equal("mispredicted update seen", 1'b1, mis_seen > mis_base);
        check_equal("pred_stall empty", 1'b0, pred_stall);
        close_test();
    endtask

    initial begin
        void'($urandom(36));
        clk         = 1'b0;
        rst         = 1'b1;
        pred_en     = 1'b0;
        pred_stream = '0;
        cache_ready = 1'b0;
        ibuf_full   = 1'b0;
        br_redirect = '0;
        commit_num  = '0;
        load_prev   = 1'b0;
        tail_m      = '0;
        mis_seen    = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        cur_test    = "reset";
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        reset_state();
        fetch_order();
        backpressure_full();
        mispredict_redirect();
        commit_update();
        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
fetch_stream_pkg.sv
branch_resolve_pkg.sv
fsq_alloc.sv
fsq_fetch_issue.sv
fsq_entry_store.sv
fsq_commit.sv
fsq_top.sv
tb_fsq.sv

// File: Bender.yml
package:
  name: fsq

sources:
  - include_dirs:
      - .
    files:
      - fetch_stream_pkg.sv
      - branch_resolve_pkg.sv
      - fsq_alloc.sv
      - fsq_fetch_issue.sv
      - fsq_entry_store.sv
      - fsq_commit.sv
      - fsq_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fsq.sv
